//--- vlog.f
rtl/if_bus_pkg.sv
rtl/if_core_pkg.sv
rtl/if_fetch_master.sv
rtl/if_align_buffer.sv
rtl/if_fetch_top.sv
tests/if_align_buffer_sva.sv
tests/tb_if_fetch.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench
VERILATOR  ?= verilator
TOP        ?= tb_if_fetch
RTL_TOP    ?= if_fetch_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= ALL CHECKS PASSED
RTL_SRCS   := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_if_fetch.sv
`timescale 1ns/1ps

// Testbench for the instruction fetch front end
// Random memory image, random bus wait states, back-pressure and redirects
module tb_if_fetch;

  localparam int BUF_WORDS = 3;
  localparam int MEM_WORDS = 256;
  // Cycle limit of each test loop
  localparam int TIMEOUT = 20000;

  logic                    clk;
  logic                    rst_n;
  if_core_pkg::ctrl_cmd_t  ctrl;
  if_bus_pkg::wb_req_t     wb_req;
  if_bus_pkg::wb_rsp_t     wb_rsp;
  logic                    instr_valid;
  if_core_pkg::instr_out_t instr;
  logic                    instr_ready;

  // Instruction memory image, 1 KiB, wraps on the low address bits
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lfsr;
  // Address of the next instruction the consumer should see
  logic [31:0] exp_pc;
  // Bus slave state
  logic        bus_busy;
  int          wait_left;
  // Stimulus modes switched by the test sequence
  logic        wait_en;
  logic        bp_en;
  logic        redir_en;
  logic        req_en;
  // Monitor state from the previous rising edge
  logic        open_seen;
  logic [31:0] open_adr;
  logic        req_seen;
  logic        hold_seen;
  if_core_pkg::instr_out_t hold_instr;
  int          accepted;
  int          redir_cnt;
  int          redir_open;
  int          checks;
  int          errors;

  if_fetch_top #(
    .BUF_WORDS (BUF_WORDS)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl),
    .wb_o          (wb_req),
    .wb_i          (wb_rsp),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_ready_i (instr_ready)
  );

  bind if_align_buffer if_align_buffer_sva #(
    .BUF_WORDS (BUF_WORDS)
  ) u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_i  (instr_o.addr),
    .push_i        (push),
    .slot_valid_i  (valid_q),
    .wptr_i        (wptr),
    .inflight_i    (inflight_q)
  );

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // Halfword at a byte address of the memory image
  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [31:0] w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Low bits 11 mark a 32-bit instruction, anything else is compressed
  task automatic check_instr();
    logic [15:0] lo;
    logic [31:0] exp_instr;
    logic        exp_c;
    lo        = mem_half(exp_pc);
    exp_c     = (lo[1:0] != 2'b11);
    exp_instr = exp_c ? {16'h0000, lo} : {mem_half(exp_pc + 32'd2), lo};
    check_value("instr_o.addr", instr.addr, exp_pc);
    check_value("instr_o.instr", instr.instr, exp_instr);
    check_value("instr_o.compressed", 32'(instr.compressed), 32'(exp_c));
    exp_pc = exp_pc + (exp_c ? 32'd2 : 32'd4);
  endtask

  ////////////////////////////////////////
  // Clock, bus slave and stimulus
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(negedge clk) begin
    // The ack seen on the last rising edge closed the cycle
    if (wb_rsp.ack) begin
      wb_rsp.ack = 1'b0;
      bus_busy   = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        wait_left = wait_en ? int'(rand_bits(2)) : 0;
      end
      if (wait_left == 0) begin
        wb_rsp.ack = 1'b1;
        wb_rsp.dat = mem[wb_req.adr[9:2]];
      end else begin
        wait_left--;
      end
    end
    // Consumer stalls about one cycle in four
    instr_ready    = bp_en ? (rand_bits(2) != 32'd0) : 1'b1;
    ctrl.instr_req = req_en ? (rand_bits(2) != 32'd0) : 1'b1;
    ctrl.pc_set    = 1'b0;
    // Redirects go to an even address inside the image
    if (redir_en && ctrl.instr_req && rand_bits(8) < 32'd6) begin
      ctrl.pc_set      = 1'b1;
      ctrl.branch_addr = rand_bits(9) << 1;
    end
  end

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      // An open cycle keeps its address until the ack edge
      if (wb_req.stb && open_seen) begin
        check_value("wb_o.adr", wb_req.adr, open_adr);
      end
      // A read cycle raises cyc and stb together and selects every byte lane
      if (wb_req.cyc || wb_req.stb) begin
        check_value("wb_o.cyc", 32'(wb_req.cyc), 32'd1);
        check_value("wb_o.stb", 32'(wb_req.stb), 32'd1);
        check_value("wb_o.we", 32'(wb_req.we), 32'd0);
        check_value("wb_o.sel", 32'(wb_req.sel), 32'hf);
      end
      // A new cycle needs instr_req high on the edge that started it
      if (wb_req.stb && !open_seen && !req_seen) begin
        errors++;
        $display("A bus cycle started although instr_req was low, at %0t ns", $time);
      end
      open_seen = wb_req.stb && !wb_rsp.ack;
      open_adr  = wb_req.adr;
      req_seen  = ctrl.instr_req;
      // A stalled instruction waits unchanged for the consumer
      if (hold_seen && !ctrl.pc_set) begin
        check_value("instr_valid_o", 32'(instr_valid), 32'd1);
        check_value("instr_o.addr", instr.addr, hold_instr.addr);
        check_value("instr_o.instr", instr.instr, hold_instr.instr);
      end
      hold_seen  = instr_valid && !instr_ready;
      hold_instr = instr;
      if (ctrl.pc_set) begin
        redir_cnt++;
        if (wb_req.cyc) begin
          redir_open++;
        end
        exp_pc = ctrl.branch_addr;
      end else if (instr_valid && instr_ready) begin
        check_instr();
        accepted++;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic run_test(input string name, input int count);
    int start_acc;
    int start_err;
    int start_redir;
    int start_open;
    int cycles;
    start_acc   = accepted;
    start_err   = errors;
    start_redir = redir_cnt;
    start_open  = redir_open;
    cycles      = 0;
    while (accepted - start_acc < count && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (accepted - start_acc < count) begin
      errors++;
      $display("Test %s timed out with %0d of %0d instructions accepted",
               name, accepted - start_acc, count);
    end
    $display("Test %s done: %0d instructions, %0d redirects (%0d with a cycle open), %0d errors",
             name, accepted - start_acc, redir_cnt - start_redir,
             redir_open - start_open, errors - start_err);
  endtask

  initial begin
    rst_n            = 1'b0;
    ctrl             = '0;
    ctrl.instr_req   = 1'b1;
    wb_rsp           = '0;
    instr_ready      = 1'b1;
    lfsr             = 32'd76373;
    exp_pc           = '0;
    bus_busy         = 1'b0;
    wait_left        = 0;
    {wait_en, bp_en, redir_en, req_en} = '0;
    open_seen        = 1'b0;
    open_adr         = '0;
    req_seen         = 1'b0;
    hold_seen        = 1'b0;
    hold_instr       = '0;
    {accepted, redir_cnt, redir_open, checks, errors} = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = rand_bits(32);
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("wb_o.cyc", 32'(wb_req.cyc), 32'd0);
    check_value("wb_o.stb", 32'(wb_req.stb), 32'd0);
    check_value("instr_valid_o", 32'(instr_valid), 32'd0);
    run_test("sequential", 200);
    wait_en = 1'b1;
    run_test("wait_states", 200);
    bp_en = 1'b1;
    run_test("backpressure", 200);
    redir_en = 1'b1;
    run_test("redirect", 400);
    redir_en = 1'b0;
    req_en   = 1'b1;
    run_test("bus_protocol", 200);
    $display("Summary: %0d checks, %0d errors, %0d instructions", checks, errors, accepted);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tests/if_align_buffer_sva.sv
`timescale 1ns/1ps

// Concurrent assertions on the alignment buffer
// Internal FIFO state comes in through the bind port list
module if_align_buffer_sva #(
  parameter int BUF_WORDS = 3
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         pc_set_i,
  input logic [31:0]                  branch_addr_i,
  input logic                         instr_valid_i,
  input logic                         instr_ready_i,
  input logic [31:0]                  instr_addr_i,
  input logic                         push_i,
  input logic [BUF_WORDS-1:0]         slot_valid_i,
  input logic [$clog2(BUF_WORDS)-1:0] wptr_i,
  input logic [1:0]                   inflight_i
);

  // Set by a redirect, cleared once the first instruction after it leaves
  logic        first_q;
  // Halfword aligned target of the last redirect
  logic [31:0] target_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q  <= 1'b0;
      target_q <= '0;
    end else if (pc_set_i) begin
      first_q  <= 1'b1;
      target_q <= {branch_addr_i[31:1], 1'b0};
    end else if (instr_valid_i && instr_ready_i) begin
      first_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !slot_valid_i[wptr_i])
    else $error("Word written into an occupied FIFO slot");

  a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |=> (slot_valid_i == '0))
    else $error("FIFO not empty after a redirect");

  a_no_valid_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> !instr_valid_i)
    else $error("Instruction offered in a redirect cycle");

  a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (first_q && instr_valid_i) |-> (instr_addr_i == target_q))
    else $error("First instruction after a redirect has the wrong address");

  // Wishbone classic leaves room for a single open read
  a_one_inflight: assert property (@(posedge clk) disable iff (!rst_n)
    inflight_i <= 2'd1)
    else $error("More than one read in flight");

endmodule

//--- rtl/if_fetch_top.sv
`timescale 1ns/1ps

// Instruction fetch front end
// Fetch master on the bus side, alignment buffer on the decode side
module if_fetch_top #(
  parameter int BUF_WORDS = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_core_pkg::ctrl_cmd_t  ctrl_i,
  output if_bus_pkg::wb_req_t     wb_o,
  input  if_bus_pkg::wb_rsp_t     wb_i,
  output logic                    instr_valid_o,
  output if_core_pkg::instr_out_t instr_o,
  input  logic                    instr_ready_i
);

  // Handshake between the two stages
  logic                     room;
  logic                     word_valid;
  if_core_pkg::fetch_word_t word;

  if_fetch_master u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .room_i       (room),
    .wb_o         (wb_o),
    .wb_i         (wb_i),
    .word_valid_o (word_valid),
    .word_o       (word)
  );

  // The buffer only needs the redirect part of the controller command
  if_align_buffer #(
    .BUF_WORDS (BUF_WORDS)
  ) u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (ctrl_i.pc_set),
    .branch_addr_i (ctrl_i.branch_addr),
    .word_valid_i  (word_valid),
    .word_i        (word),
    .room_o        (room),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_ready_i (instr_ready_i)
  );

endmodule

//--- rtl/if_align_buffer.sv
`timescale 1ns/1ps

// Align stage
// Holds fetched words and cuts them into 16-bit and 32-bit instructions
module if_align_buffer #(
  parameter int BUF_WORDS = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic [31:0]              branch_addr_i,
  input  logic                     word_valid_i,
  input  if_core_pkg::fetch_word_t word_i,
  output logic                     room_o,
  output logic                     instr_valid_o,
  output if_core_pkg::instr_out_t  instr_o,
  input  logic                     instr_ready_i
);

  localparam int PW = (BUF_WORDS > 1) ? $clog2(BUF_WORDS) : 1;
  localparam int CW = $clog2(BUF_WORDS + 1);

  // Word storage and its occupancy
  logic [31:0]          mem [BUF_WORDS];
  logic [BUF_WORDS-1:0] valid_q;
  logic [PW-1:0]        wptr;
  logic [PW-1:0]        rptr;
  logic [PW-1:0]        rptr_nx;
  logic [CW-1:0]        cnt_q;
  // Reads granted by room_o whose word has not arrived yet
  logic [1:0]           inflight_q;
  // Halfword offset of the next instruction inside the head word
  logic                 hw_q;
  // Address of the next instruction
  logic [31:0]          addr_q;
  logic [31:0]          head_w;
  logic [31:0]          next_w;
  logic [15:0]          first_hw;
  logic                 compressed;
  logic                 avail;
  logic [31:0]          instr;
  logic                 push;
  logic                 pop;
  logic                 pop_word;

  // Circular pointer step for a depth that need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    logic [PW-1:0] res;
    if (ptr == PW'(BUF_WORDS - 1)) begin
      res = '0;
    end else begin
      res = ptr + 1'b1;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Extraction
  ////////////////////////////////////////

  always_comb begin
    rptr_nx  = ptr_inc(rptr);
    head_w   = mem[rptr];
    next_w   = mem[rptr_nx];
    first_hw = hw_q ? head_w[31:16] : head_w[15:0];
    // RISC-V marks a 32-bit instruction with 11 in the two lowest bits
    compressed = (first_hw[1:0] != 2'b11);
    if (compressed) begin
      avail = valid_q[rptr];
      instr = {16'h0000, first_hw};
    end else if (!hw_q) begin
      avail = valid_q[rptr];
      instr = head_w;
    end else begin
      // The upper half lives in the low halfword of the following word
      avail = valid_q[rptr] & valid_q[rptr_nx];
      instr = {next_w[15:0], head_w[31:16]};
    end
  end

  // Nothing leaves in a redirect cycle, the contents are stale by then
  assign instr_valid_o      = avail & ~pc_set_i;
  assign instr_o.addr       = addr_q;
  assign instr_o.instr      = instr;
  assign instr_o.compressed = compressed;

  assign push     = word_valid_i & ~pc_set_i;
  assign pop      = instr_valid_o & instr_ready_i;
  // The head word is used up unless a compressed instruction leaves its upper half
  assign pop_word = pop & (hw_q | ~compressed);

  // Free slot beyond held words and the word in flight
  assign room_o = (int'(cnt_q) + int'(inflight_q)) < BUF_WORDS;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= word_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr    <= '0;
      rptr    <= '0;
      cnt_q   <= '0;
      hw_q    <= 1'b0;
      addr_q  <= '0;
    end else if (pc_set_i) begin
      // Flush and restart at the target, possibly in the upper halfword
      valid_q <= '0;
      wptr    <= '0;
      rptr    <= '0;
      cnt_q   <= '0;
      hw_q    <= branch_addr_i[1];
      addr_q  <= {branch_addr_i[31:1], 1'b0};
    end else begin
      if (push) begin
        valid_q[wptr] <= 1'b1;
        wptr          <= ptr_inc(wptr);
      end
      if (pop_word) begin
        valid_q[rptr] <= 1'b0;
        rptr          <= rptr_nx;
      end
      cnt_q <= cnt_q + CW'(push) - CW'(pop_word);
      if (pop) begin
        hw_q   <= hw_q ^ compressed;
        addr_q <= addr_q + (compressed ? 32'd2 : 32'd4);
      end
    end
  end

  // A grant is counted on the edge where room_o is seen with nothing outstanding
  // The fetch master takes the same grant on the same edge
  // A redirect keeps an open grant, and only a word arrival returns it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight_q <= '0;
    end else if (word_valid_i) begin
      inflight_q <= inflight_q - 2'd1;
    end else if (room_o && inflight_q == 2'd0) begin
      inflight_q <= inflight_q + 2'd1;
    end
  end

endmodule

//--- rtl/if_fetch_master.sv
`timescale 1ns/1ps

// Fetch stage
// Reads aligned words over Wishbone classic with at most one open cycle
module if_fetch_master (
  input  logic                     clk,
  input  logic                     rst_n,
  input  if_core_pkg::ctrl_cmd_t   ctrl_i,
  input  logic                     room_i,
  output if_bus_pkg::wb_req_t      wb_o,
  input  if_bus_pkg::wb_rsp_t      wb_i,
  output logic                     word_valid_o,
  output if_core_pkg::fetch_word_t word_o
);

  // Word address width, the byte offset bits are always zero
  localparam int WA = if_bus_pkg::WB_AW - 2;

  // Next word address to fetch
  logic [WA-1:0] next_q;
  // Word address of the open cycle, held stable until ack
  logic [WA-1:0] adr_q;
  // A bus cycle is open
  logic          open_q;
  // The response of the open cycle belongs to the old stream
  logic          discard_q;
  // The align buffer has set a slot aside for our next response
  // This mirrors the in-flight count kept by the buffer
  logic          slot_q;
  logic          ack;
  logic          issue;
  logic [WA-1:0] start_adr;

  ////////////////////////////////////////
  // Request and response decode
  ////////////////////////////////////////

  assign ack = open_q & wb_i.ack;

  // A response is forwarded unless a redirect made it stale
  // A redirect on the ack edge itself also drops the word
  assign word_valid_o = ack & ~discard_q & ~ctrl_i.pc_set;

  // Start a cycle when a buffer slot is ours and the controller wants instructions
  assign issue = (slot_q | room_i) & ctrl_i.instr_req & ~open_q;

  // A cycle started on the redirect edge goes straight to the target word
  assign start_adr = ctrl_i.pc_set ? ctrl_i.branch_addr[if_bus_pkg::WB_AW-1:2] : next_q;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_q    <= '0;
      open_q    <= 1'b0;
      discard_q <= 1'b0;
      slot_q    <= 1'b0;
    end else begin
      // The fetch address follows redirects and steps one word per accepted response
      if (ctrl_i.pc_set) begin
        next_q <= ctrl_i.branch_addr[if_bus_pkg::WB_AW-1:2];
      end else if (word_valid_o) begin
        next_q <= next_q + 1'b1;
      end

      // The open flag rises on issue and falls on the ack edge
      if (issue) begin
        open_q <= 1'b1;
      end else if (ack) begin
        open_q <= 1'b0;
      end

      // A redirect during an open cycle lets the cycle finish and drops its data
      if (ack) begin
        discard_q <= 1'b0;
      end else if (ctrl_i.pc_set && open_q) begin
        discard_q <= 1'b1;
      end

      // A dropped response keeps the slot, so the restarted fetch reuses it
      slot_q <= word_valid_o ? 1'b0 : (slot_q | room_i);
    end
  end

  // Address of the cycle, only sampled while cyc is high
  always_ff @(posedge clk) begin
    if (issue) begin
      adr_q <= start_adr;
    end
  end

  ////////////////////////////////////////
  // Bus and word outputs
  ////////////////////////////////////////

  always_comb begin
    wb_o     = '0;
    wb_o.cyc = open_q;
    wb_o.stb = open_q;
    wb_o.we  = 1'b0;
    wb_o.sel = '1;
    wb_o.adr = {adr_q, 2'b00};
  end

  assign word_o.addr = adr_q;
  assign word_o.data = wb_i.dat;

endmodule

//--- rtl/if_core_pkg.sv
// Core side definitions of the fetch front end
package if_core_pkg;

  // Architectural register and address width
  parameter int XLEN = 32;

  ////////////////////////////////////////
  // Controller to fetch
  ////////////////////////////////////////

  // Command from the core controller
  // A redirect is only legal while fetching is allowed
  typedef struct packed {
    logic            instr_req;
    logic            pc_set;
    logic [XLEN-1:0] branch_addr;
  } ctrl_cmd_t;

  ////////////////////////////////////////
  // Inside the front end and towards decode
  ////////////////////////////////////////

  // One fetched word tagged with its word address (byte address bits 31:2)
  typedef struct packed {
    logic [XLEN-3:0] addr;
    logic [XLEN-1:0] data;
  } fetch_word_t;

  // One extracted instruction
  // For compressed instructions the upper halfword is zero
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] instr;
    logic            compressed;
  } instr_out_t;

endpackage

//--- rtl/if_bus_pkg.sv
// Wishbone bus definitions shared by the fetch master and the bus side of the top
package if_bus_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // Byte address width of the instruction bus
  parameter int WB_AW = 32;
  // Data width of the instruction bus, one full instruction word
  parameter int WB_DW = 32;
  // One select bit per byte lane
  localparam int WB_SW = WB_DW / 8;

  ////////////////////////////////////////
  // Master and slave bundles
  ////////////////////////////////////////

  // Signals driven by the master
  // The fetch path only reads, so we stays low and every byte lane is selected
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_SW-1:0] sel;
    logic [WB_AW-1:0] adr;
  } wb_req_t;

  // Signals driven by the slave
  // The read data is only meaningful on the edge where ack is high
  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage
